// File: verilog.f
+incdir+hw
hw/mips_pkg.sv
hw/pipe_reg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/decode_stage.sv
sim/decode_stage_asserts.sv
sim/decode_stage_tb.sv

// File: Bender.yml
package:
  name: mips_decode_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/pipe_reg.sv
      - hw/regfile.sv
      - hw/inst_decoder.sv
      - hw/operand_forward.sv
      - hw/branch_unit.sv
      - hw/decode_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/decode_stage_asserts.sv
      - sim/decode_stage_tb.sv

// File: sim/decode_stage_tb.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module decode_stage_tb;

	localparam int MAX_CYCLES = 4000;  // tests use about 350

	logic             clk_i;
	logic             arst_n_i;
	logic             fetch_valid_i;
	logic             fetch_ready_o;
	mips_pkg::fetch_t fetch_i;
	logic             issue_valid_o;
	logic             issue_ready_i;
	mips_pkg::issue_t issue_o;
	mips_pkg::fwd_t   ex_fwd_i;
	mips_pkg::fwd_t   mem_fwd_i;
	mips_pkg::wb_t    wb_i;

	logic [31:0]      shadow [32];  // mirror of the register file
	mips_pkg::issue_t exp_q [$];
	mips_pkg::fwd_t   model_ex;     // forwarding in effect when the instruction issues
	mips_pkg::fwd_t   model_mem;
	logic             prev_br;
	logic [31:0]      pc_next;
	logic [31:0]      stim_state;
	logic [31:0]      ready_state;
	logic             rand_ready;
	int               cycles = 0;
	string            test_name;

	decode_stage UUT (
		.clk_i, .arst_n_i, .fetch_valid_i, .fetch_ready_o, .fetch_i,
		.issue_valid_o, .issue_ready_i, .issue_o, .ex_fwd_i, .mem_fwd_i, .wb_i
	);

	bind decode_stage decode_stage_asserts u_asserts (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.fetch_valid_i(fetch_valid_i), .fetch_ready_i(fetch_ready_o),
		.fetch_full_i(fetch_q_valid), .hazard1_i(hazard1), .hazard2_i(hazard2),
		.issue_valid_i(issue_valid_o), .issue_ready_i(issue_ready_i), .issue_i(issue_o)
	);

	////////////////////////////////////////////////////////////
	// random numbers and instruction words
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_state = xorshift32(stim_state);
		return stim_state;
	endfunction

	function automatic logic [31:0] r_inst(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	// one of the kept alu, immediate, lw and sw words
	function automatic logic [31:0] rand_alu_inst();
		logic [31:0] r;
		logic [31:0] w;
		r = next_rand();
		w = next_rand();  // register fields and immediate
		case (r % 15)
			0:       w = r_inst(`MIPS_FN_OR, w[25:21], w[20:16], w[15:11]);
			1:       w = r_inst(`MIPS_FN_AND, w[25:21], w[20:16], w[15:11]);
			2:       w = r_inst(`MIPS_FN_XOR, w[25:21], w[20:16], w[15:11]);
			3:       w = r_inst(`MIPS_FN_NOR, w[25:21], w[20:16], w[15:11]);
			4:       w = r_inst(`MIPS_FN_ADDU, w[25:21], w[20:16], w[15:11]);
			5:       w = r_inst(`MIPS_FN_SUBU, w[25:21], w[20:16], w[15:11]);
			6:       w = r_inst(`MIPS_FN_SLT, w[25:21], w[20:16], w[15:11]);
			7:       w = {`MIPS_OP_ORI, w[25:0]};
			8:       w = {`MIPS_OP_ANDI, w[25:0]};
			9:       w = {`MIPS_OP_XORI, w[25:0]};
			10:      w = {`MIPS_OP_LUI, 5'd0, w[20:0]};
			11:      w = {`MIPS_OP_ADDIU, w[25:0]};
			12:      w = {`MIPS_OP_SLTI, w[25:0]};
			13:      w = {`MIPS_OP_LW, w[25:0]};
			default: w = {`MIPS_OP_SW, w[25:0]};
		endcase
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] src_value(input logic [4:0] r, input mips_pkg::fwd_t ex,
		input mips_pkg::fwd_t mem);
		if (ex.we && ex.waddr == r)
			return ex.wdata;
		if (mem.we && mem.waddr == r)
			return mem.wdata;
		return shadow[r];
	endfunction

	function automatic mips_pkg::issue_t ref_issue(input mips_pkg::fetch_t f,
		input mips_pkg::fwd_t ex, input mips_pkg::fwd_t mem, input logic after_br);
		mips_pkg::issue_t   e;
		mips_pkg::alu_op_e  aop;
		mips_pkg::br_kind_e kind;
		logic [31:0]        imm;
		logic [31:0]        pc4;
		logic               valid;
		logic               use_rs;
		logic               use_rt;
		logic               itype;
		e      = '0;
		aop    = mips_pkg::ALU_NOP;
		kind   = mips_pkg::BR_NONE;
		imm    = '0;
		pc4    = f.pc + 32'd4;
		valid  = 1'b1;
		use_rs = 1'b0;
		use_rt = 1'b0;
		itype  = 1'b0;
		case (f.inst[31:26])
			`MIPS_OP_SPECIAL: begin
				use_rs  = 1'b1;
				use_rt  = 1'b1;
				e.we    = 1'b1;
				e.waddr = f.inst[15:11];
				case (f.inst[5:0])
					`MIPS_FN_OR:   aop = mips_pkg::ALU_OR;
					`MIPS_FN_AND:  aop = mips_pkg::ALU_AND;
					`MIPS_FN_XOR:  aop = mips_pkg::ALU_XOR;
					`MIPS_FN_NOR:  aop = mips_pkg::ALU_NOR;
					`MIPS_FN_ADDU: aop = mips_pkg::ALU_ADDU;
					`MIPS_FN_SUBU: aop = mips_pkg::ALU_SUBU;
					`MIPS_FN_SLT:  aop = mips_pkg::ALU_SLT;
					`MIPS_FN_JR: begin
						kind    = mips_pkg::BR_JREG;
						use_rt  = 1'b0;
						e.we    = 1'b0;
						e.waddr = '0;
					end
					default: valid = 1'b0;
				endcase
			end
			`MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI: begin
				itype = 1'b1;
				imm   = {16'h0, f.inst[15:0]};  // logic immediates zero-extend
				case (f.inst[31:26])
					`MIPS_OP_ORI:  aop = mips_pkg::ALU_OR;
					`MIPS_OP_ANDI: aop = mips_pkg::ALU_AND;
					default:       aop = mips_pkg::ALU_XOR;
				endcase
			end
			`MIPS_OP_LUI: begin
				itype = 1'b1;
				aop   = mips_pkg::ALU_OR;
				imm   = {f.inst[15:0], 16'h0};
			end
			`MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_LW: begin
				itype = 1'b1;
				imm   = {{16{f.inst[15]}}, f.inst[15:0]};
				case (f.inst[31:26])
					`MIPS_OP_ADDIU: aop = mips_pkg::ALU_ADDU;
					`MIPS_OP_SLTI:  aop = mips_pkg::ALU_SLT;
					default:        aop = mips_pkg::ALU_LW;
				endcase
			end
			`MIPS_OP_SW: begin
				aop    = mips_pkg::ALU_SW;
				imm    = {{16{f.inst[15]}}, f.inst[15:0]};
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
				kind   = (f.inst[26]) ? mips_pkg::BR_BNE : mips_pkg::BR_BEQ;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			`MIPS_OP_J: kind = mips_pkg::BR_JABS;
			`MIPS_OP_JAL: begin
				kind        = mips_pkg::BR_JABS;
				aop         = mips_pkg::ALU_JAL;
				e.we        = 1'b1;
				e.waddr     = 5'(`MIPS_LINK_REG);
				e.link_addr = f.pc + 32'd8;
			end
			default: valid = 1'b0;
		endcase
		if (itype) begin
			use_rs  = 1'b1;
			e.we    = 1'b1;
			e.waddr = f.inst[20:16];
		end
		if (!valid) begin  // unknown word, nothing enabled
			use_rs  = 1'b0;
			use_rt  = 1'b0;
			e.we    = 1'b0;
			e.waddr = '0;
			imm     = '0;
		end
		e.pc         = f.pc;
		e.inst       = f.inst;
		e.alu_op     = aop;
		e.inst_valid = valid;
		e.delay_slot = after_br;
		e.op1        = use_rs ? src_value(f.inst[25:21], ex, mem) : imm;
		e.op2        = use_rt ? src_value(f.inst[20:16], ex, mem) : imm;
		if (kind != mips_pkg::BR_NONE) begin
			e.alu_sel = mips_pkg::SEL_JUMP;
		end else begin
			case (aop)
				mips_pkg::ALU_OR, mips_pkg::ALU_AND,
				mips_pkg::ALU_XOR, mips_pkg::ALU_NOR: e.alu_sel = mips_pkg::SEL_LOGIC;
				mips_pkg::ALU_ADDU, mips_pkg::ALU_SUBU,
				mips_pkg::ALU_SLT:                    e.alu_sel = mips_pkg::SEL_ARITH;
				mips_pkg::ALU_LW, mips_pkg::ALU_SW:   e.alu_sel = mips_pkg::SEL_LOADSTORE;
				default:                              e.alu_sel = mips_pkg::SEL_NOP;
			endcase
		end
		case (kind)
			mips_pkg::BR_BEQ, mips_pkg::BR_BNE: begin
				e.br_taken  = (kind == mips_pkg::BR_BEQ) ? (e.op1 == e.op2) : (e.op1 != e.op2);
				e.br_target = pc4 + {{14{f.inst[15]}}, f.inst[15:0], 2'b00};
			end
			mips_pkg::BR_JABS: begin
				e.br_taken  = 1'b1;
				e.br_target = {pc4[31:28], f.inst[25:0], 2'b00};
			end
			mips_pkg::BR_JREG: begin
				e.br_taken  = 1'b1;
				e.br_target = e.op1;
			end
			default: ;
		endcase
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// driving tasks
	////////////////////////////////////////////////////////////
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic offer_inst(input logic [31:0] inst, output mips_pkg::fetch_t f);
		f.pc          = pc_next;
		f.inst        = inst;
		pc_next       = pc_next + 32'd4;
		fetch_i       = f;
		fetch_valid_i = 1'b1;
	endtask

	// waits for the fetch transfer and queues the model's result
	task automatic wait_accept(input mips_pkg::fetch_t f);
		mips_pkg::issue_t e;
		do begin
			@(negedge clk_i);
		end while (!fetch_ready_o);
		e = ref_issue(f, model_ex, model_mem, prev_br);
		exp_q.push_back(e);
		prev_br = (e.alu_sel == mips_pkg::SEL_JUMP);
		@(posedge clk_i);
		#10;
		fetch_valid_i = 1'b0;
	endtask

	task automatic send_inst(input logic [31:0] inst);
		mips_pkg::fetch_t f;
		offer_inst(inst, f);
		wait_accept(f);
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0)
			@(posedge clk_i);
		@(posedge clk_i);
		#10;
	endtask

	task automatic set_fwd(input mips_pkg::fwd_t ex, input mips_pkg::fwd_t mem);
		wait_idle();
		ex_fwd_i  = ex;
		mem_fwd_i = mem;
		model_ex  = ex;
		model_mem = mem;
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wb_i.en      = 1'b1;
		wb_i.addr    = addr;
		wb_i.data    = data;
		shadow[addr] = data;
		@(posedge clk_i);
		#10;
		wb_i = '0;
	endtask

	////////////////////////////////////////////////////////////
	// clock, ready pattern, timeout, comparison
	////////////////////////////////////////////////////////////
	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		#10;
		if (rand_ready) begin
			ready_state   = xorshift32(ready_state);
			issue_ready_i = ready_state[7];
		end else begin
			issue_ready_i = 1'b1;
		end
	end

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			fail_run("timeout, the tests did not finish within the cycle limit");
	end

	always @(negedge clk_i) begin : compare
		mips_pkg::issue_t exp_item;
		assert (!UUT.u_asserts.fired) else fail_run("a bound protocol assertion failed");
		if (arst_n_i && issue_valid_o && issue_ready_i) begin
			assert (exp_q.size() != 0)
				else fail_run("issue transfer without an outstanding instruction");
			if (exp_q.size() != 0) begin
				exp_item = exp_q.pop_front();
				assert (issue_o === exp_item) else begin
					$display("ERROR %s: expected %h actual %h", test_name, exp_item, issue_o);
					fail_run("issued instruction differs from the model");
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////
	initial begin : stimulus
		logic [31:0]      d;
		mips_pkg::fwd_t   ex;
		mips_pkg::fwd_t   mem;
		mips_pkg::fetch_t f;
		arst_n_i      = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_i       = '0;
		issue_ready_i = 1'b1;
		ex_fwd_i      = '0;
		mem_fwd_i     = '0;
		wb_i          = '0;
		model_ex      = '0;
		model_mem     = '0;
		prev_br       = 1'b0;
		pc_next       = 32'h0040_0000;
		stim_state    = 32'd97;
		ready_state   = 32'd97;
		rand_ready    = 1'b0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;

		test_name = "reset";
		repeat (2) @(posedge clk_i);
		#10;
		arst_n_i = 1'b1;
		@(negedge clk_i);
		assert (!issue_valid_o && fetch_ready_o) else begin
			$display("ERROR %s: expected valid 0 ready 1 actual valid %b ready %b",
				test_name, issue_valid_o, fetch_ready_o);
			fail_run("handshake outputs wrong after reset");
		end
		@(posedge clk_i);
		#10;

		test_name = "decode";
		for (int i = 1; i < 32; i++) begin
			d = next_rand();
			write_reg(5'(i), {d[31:5], 5'(i)});  // low bits keep values distinct
		end
		repeat (60) send_inst(rand_alu_inst());
		send_inst(32'h0000_0000);            // special with a dropped function
		send_inst({6'b111111, 26'h155_5555}); // unused opcode

		test_name = "forwarding";
		ex  = '{we: 1'b1, waddr: 5'd12, wdata: 32'hcafe_0001, is_load: 1'b0};
		mem = '{we: 1'b1, waddr: 5'd12, wdata: 32'hbeef_0002, is_load: 1'b0};
		set_fwd(ex, mem);
		send_inst(r_inst(`MIPS_FN_ADDU, 5'd12, 5'd13, 5'd2));
		send_inst({`MIPS_OP_ORI, 5'd12, 5'd3, 16'h0f0f});
		ex.waddr = 5'd14;  // memory alone now hits r12
		set_fwd(ex, mem);
		send_inst(r_inst(`MIPS_FN_SUBU, 5'd12, 5'd14, 5'd3));
		set_fwd('0, '0);

		test_name = "load-use";
		ex_fwd_i = '{we: 1'b1, waddr: 5'd9, wdata: 32'h0bad_0bad, is_load: 1'b1};
		send_inst(r_inst(`MIPS_FN_ADDU, 5'd9, 5'd10, 5'd4));
		offer_inst({`MIPS_OP_ORI, 5'd11, 5'd5, 16'h00ff}, f);
		repeat (8) begin
			@(negedge clk_i);
			assert (!issue_valid_o) else fail_run("instruction issued during a load-use hold");
			assert (!fetch_ready_o) else fail_run("fetch still ready during a load-use hold");
		end
		@(posedge clk_i);
		#10;
		ex_fwd_i = '0;
		wait_accept(f);
		wait_idle();

		test_name = "branches";
		pc_next = 32'h9000_1000;
		send_inst({`MIPS_OP_BEQ, 5'd3, 5'd3, 16'hfff0});  // taken, backward
		send_inst(r_inst(`MIPS_FN_OR, 5'd1, 5'd2, 5'd6));
		send_inst({`MIPS_OP_BEQ, 5'd3, 5'd4, 16'h0010});  // not taken
		send_inst(rand_alu_inst());
		send_inst({`MIPS_OP_BNE, 5'd3, 5'd4, 16'h0020});  // taken
		send_inst(rand_alu_inst());
		send_inst({`MIPS_OP_BNE, 5'd5, 5'd5, 16'h8000});  // not taken
		send_inst(rand_alu_inst());
		send_inst({`MIPS_OP_J, 26'h2ab_cdef});
		send_inst(rand_alu_inst());
		send_inst({`MIPS_OP_JAL, 26'h012_3456});
		send_inst(rand_alu_inst());
		send_inst(r_inst(`MIPS_FN_JR, 5'd7, 5'd0, 5'd0));
		send_inst(rand_alu_inst());
		wait_idle();

		test_name = "back-pressure";
		rand_ready = 1'b1;
		repeat (40) send_inst(rand_alu_inst());
		rand_ready = 1'b0;
		repeat (4) @(posedge clk_i);  // at most two in flight, ready now high
		#10;

		assert (exp_q.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_run("accepted instructions never left the stage");
		end
	end

endmodule

`default_nettype wire

// File: sim/decode_stage_asserts.sv
`default_nettype none
`timescale 1ns/1ns

module decode_stage_asserts (
	input wire                   clk_i,
	input wire                   arst_n_i,
	input wire                   fetch_valid_i,
	input wire                   fetch_ready_i,
	input wire                   fetch_full_i,
	input wire                   hazard1_i,
	input wire                   hazard2_i,
	input wire                   issue_valid_i,
	input wire                   issue_ready_i,
	input wire mips_pkg::issue_t issue_i
);

	logic fired = 1'b0;  // sticky, any assertion failure

	// stalled output keeps valid and payload
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_i))
		else begin
			$error("issue payload or valid changed while the output was stalled");
			fired = 1'b1;
		end

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(fetch_full_i && (hazard1_i || hazard2_i) && fetch_valid_i && fetch_ready_i))
		else begin
			$error("fetch transfer into an input register held by a load-use hazard");
			fired = 1'b1;
		end

	assert property (@(posedge clk_i) $rose(arst_n_i) |-> !issue_valid_i)
		else begin
			$error("issue valid is high right after reset");
			fired = 1'b1;
		end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
	input  wire                 clk_i,
	input  wire                 arst_n_i,
	input  wire                 fetch_valid_i,
	output logic                fetch_ready_o,
	input  wire mips_pkg::fetch_t fetch_i,
	output logic                issue_valid_o,
	input  wire                 issue_ready_i,
	output mips_pkg::issue_t    issue_o,
	input  wire mips_pkg::fwd_t ex_fwd_i,
	input  wire mips_pkg::fwd_t mem_fwd_i,
	input  wire mips_pkg::wb_t  wb_i
);

	mips_pkg::fetch_t         fetch_q;
	logic                     fetch_q_valid;
	logic                     fetch_q_ready;
	mips_pkg::ctrl_t          ctrl;
	mips_pkg::issue_t         issue_d;
	logic                     issue_in_ready;
	logic [`MIPS_RADDR_W-1:0] rs;
	logic [`MIPS_RADDR_W-1:0] rt;
	logic [`MIPS_XLEN-1:0]    rf_data1;
	logic [`MIPS_XLEN-1:0]    rf_data2;
	logic [`MIPS_XLEN-1:0]    op1;
	logic [`MIPS_XLEN-1:0]    op2;
	logic                     hazard1;
	logic                     hazard2;
	logic                     br_taken;
	logic [`MIPS_XLEN-1:0]    br_target;
	logic [`MIPS_XLEN-1:0]    link_addr;
	logic                     advance;
	logic                     delay_slot_q;

	assign rs = fetch_q.inst[25:21];
	assign rt = fetch_q.inst[20:16];

	////////////////////////////////////////////////////////////
	// input register, decode, operands
	////////////////////////////////////////////////////////////
	pipe_reg #(.payload_t(mips_pkg::fetch_t)) u_fetch_reg (
		.clk_i, .arst_n_i,
		.in_valid_i(fetch_valid_i), .in_ready_o(fetch_ready_o), .in_i(fetch_i),
		.out_valid_o(fetch_q_valid), .out_ready_i(fetch_q_ready), .out_o(fetch_q)
	);

	regfile u_regfile (
		.clk_i, .arst_n_i, .wb_i,
		.raddr1_i(rs), .raddr2_i(rt), .rdata1_o(rf_data1), .rdata2_o(rf_data2)
	);

	inst_decoder u_decoder (.inst_i(fetch_q.inst), .ctrl_o(ctrl));

	operand_forward u_fwd1 (
		.read_en_i(ctrl.reg1_re), .addr_i(rs), .rf_data_i(rf_data1), .imm_i(ctrl.imm),
		.ex_fwd_i, .mem_fwd_i, .operand_o(op1), .hazard_o(hazard1)
	);

	operand_forward u_fwd2 (
		.read_en_i(ctrl.reg2_re), .addr_i(rt), .rf_data_i(rf_data2), .imm_i(ctrl.imm),
		.ex_fwd_i, .mem_fwd_i, .operand_o(op2), .hazard_o(hazard2)
	);

	branch_unit u_branch (
		.kind_i(ctrl.br_kind), .pc_i(fetch_q.pc), .inst_i(fetch_q.inst),
		.op1_i(op1), .op2_i(op2),
		.taken_o(br_taken), .target_o(br_target), .link_addr_o(link_addr)
	);

	////////////////////////////////////////////////////////////
	// advance and issue
	////////////////////////////////////////////////////////////
	assign advance       = fetch_q_valid & ~(hazard1 | hazard2);  // load-use holds here
	assign fetch_q_ready = advance & issue_in_ready;

	// instruction after any branch or jump sits in the delay slot
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			delay_slot_q <= 1'b0;
		end else if (fetch_q_ready) begin
			delay_slot_q <= (ctrl.br_kind != mips_pkg::BR_NONE);
		end
	end

	always_comb begin
		issue_d.pc         = fetch_q.pc;
		issue_d.inst       = fetch_q.inst;
		issue_d.alu_op     = ctrl.alu_op;
		issue_d.alu_sel    = ctrl.alu_sel;
		issue_d.op1        = op1;
		issue_d.op2        = op2;
		issue_d.waddr      = ctrl.waddr;
		issue_d.we         = ctrl.we;
		issue_d.link_addr  = ctrl.link ? link_addr : '0;  // jal only
		issue_d.br_taken   = br_taken;
		issue_d.br_target  = br_target;
		issue_d.delay_slot = delay_slot_q;
		issue_d.inst_valid = ctrl.inst_valid;
	end

	pipe_reg #(.payload_t(mips_pkg::issue_t)) u_issue_reg (
		.clk_i, .arst_n_i,
		.in_valid_i(advance), .in_ready_o(issue_in_ready), .in_i(issue_d),
		.out_valid_o(issue_valid_o), .out_ready_i(issue_ready_i), .out_o(issue_o)
	);

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module branch_unit (
	input  wire mips_pkg::br_kind_e kind_i,
	input  wire [`MIPS_XLEN-1:0]    pc_i,
	input  wire [`MIPS_XLEN-1:0]    inst_i,
	input  wire [`MIPS_XLEN-1:0]    op1_i,
	input  wire [`MIPS_XLEN-1:0]    op2_i,
	output logic                    taken_o,
	output logic [`MIPS_XLEN-1:0]   target_o,
	output logic [`MIPS_XLEN-1:0]   link_addr_o
);

	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] br_offset;

	assign pc_plus4    = pc_i + `MIPS_XLEN'd4;
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};  // word offset
	assign link_addr_o = pc_i + `MIPS_XLEN'd8;  // skips the delay slot

	always_comb begin
		taken_o  = 1'b0;
		target_o = '0;
		case (kind_i)
			mips_pkg::BR_BEQ: begin
				taken_o  = (op1_i == op2_i);
				target_o = pc_plus4 + br_offset;
			end
			mips_pkg::BR_BNE: begin
				taken_o  = (op1_i != op2_i);
				target_o = pc_plus4 + br_offset;
			end
			mips_pkg::BR_JABS: begin
				taken_o  = 1'b1;
				target_o = {pc_plus4[`MIPS_XLEN-1 -: 4], inst_i[25:0], 2'b00};
			end
			mips_pkg::BR_JREG: begin
				taken_o  = 1'b1;
				target_o = op1_i;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/operand_forward.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module operand_forward (
	input  wire                     read_en_i,
	input  wire [`MIPS_RADDR_W-1:0] addr_i,
	input  wire [`MIPS_XLEN-1:0]    rf_data_i,
	input  wire [`MIPS_XLEN-1:0]    imm_i,
	input  wire mips_pkg::fwd_t     ex_fwd_i,
	input  wire mips_pkg::fwd_t     mem_fwd_i,
	output logic [`MIPS_XLEN-1:0]   operand_o,
	output logic                    hazard_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == addr_i);
	assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == addr_i);

	// youngest result wins
	always_comb begin
		if (!read_en_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

	// load data not there until after mem
	assign hazard_o = read_en_i && ex_fwd_i.is_load && (ex_fwd_i.waddr == addr_i);

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module inst_decoder (
	input  wire [`MIPS_XLEN-1:0] inst_i,
	output mips_pkg::ctrl_t      ctrl_o
);

	logic [5:0]               opcode;
	logic [5:0]               funct;
	logic [`MIPS_RADDR_W-1:0] rt;
	logic [`MIPS_RADDR_W-1:0] rd;
	logic [`MIPS_XLEN-1:0]    imm_zx;
	logic [`MIPS_XLEN-1:0]    imm_sx;
	logic [`MIPS_XLEN-1:0]    imm_hi;
	logic                     itype;  // rs op imm -> rt

	assign opcode = inst_i[31:26];
	assign funct  = inst_i[5:0];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign imm_zx = {16'h0, inst_i[15:0]};
	assign imm_sx = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_hi = {inst_i[15:0], 16'h0};

	////////////////////////////////////////////////////////////
	// opcode and function decode
	////////////////////////////////////////////////////////////
	always_comb begin
		ctrl_o = '0;  // unknown word -> nop, invalid
		itype  = 1'b0;
		case (opcode)
			`MIPS_OP_SPECIAL: begin
				ctrl_o.reg1_re    = 1'b1;
				ctrl_o.reg2_re    = 1'b1;
				ctrl_o.we         = 1'b1;
				ctrl_o.waddr      = rd;
				ctrl_o.inst_valid = 1'b1;
				case (funct)
					`MIPS_FN_OR:   ctrl_o.alu_op = mips_pkg::ALU_OR;
					`MIPS_FN_AND:  ctrl_o.alu_op = mips_pkg::ALU_AND;
					`MIPS_FN_XOR:  ctrl_o.alu_op = mips_pkg::ALU_XOR;
					`MIPS_FN_NOR:  ctrl_o.alu_op = mips_pkg::ALU_NOR;
					`MIPS_FN_ADDU: ctrl_o.alu_op = mips_pkg::ALU_ADDU;
					`MIPS_FN_SUBU: ctrl_o.alu_op = mips_pkg::ALU_SUBU;
					`MIPS_FN_SLT:  ctrl_o.alu_op = mips_pkg::ALU_SLT;
					`MIPS_FN_JR: begin
						ctrl_o.reg2_re = 1'b0;
						ctrl_o.we      = 1'b0;
						ctrl_o.waddr   = '0;
						ctrl_o.br_kind = mips_pkg::BR_JREG;
					end
					default: ctrl_o = '0;
				endcase
			end
			`MIPS_OP_ORI: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_OR;
				ctrl_o.imm    = imm_zx;
			end
			`MIPS_OP_ANDI: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_AND;
				ctrl_o.imm    = imm_zx;
			end
			`MIPS_OP_XORI: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_XOR;
				ctrl_o.imm    = imm_zx;
			end
			`MIPS_OP_LUI: begin
				itype         = 1'b1;  // rs is 0, or-ed with the upper half
				ctrl_o.alu_op = mips_pkg::ALU_OR;
				ctrl_o.imm    = imm_hi;
			end
			`MIPS_OP_ADDIU: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_ADDU;
				ctrl_o.imm    = imm_sx;
			end
			`MIPS_OP_SLTI: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_SLT;
				ctrl_o.imm    = imm_sx;
			end
			`MIPS_OP_LW: begin
				itype         = 1'b1;
				ctrl_o.alu_op = mips_pkg::ALU_LW;
				ctrl_o.imm    = imm_sx;
			end
			`MIPS_OP_SW: begin
				ctrl_o.alu_op     = mips_pkg::ALU_SW;
				ctrl_o.reg1_re    = 1'b1;
				ctrl_o.reg2_re    = 1'b1;  // store data on op2
				ctrl_o.imm        = imm_sx;
				ctrl_o.inst_valid = 1'b1;
			end
			`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
				ctrl_o.reg1_re    = 1'b1;
				ctrl_o.reg2_re    = 1'b1;
				ctrl_o.inst_valid = 1'b1;
				ctrl_o.br_kind    = (opcode == `MIPS_OP_BEQ) ? mips_pkg::BR_BEQ : mips_pkg::BR_BNE;
			end
			`MIPS_OP_J: begin
				ctrl_o.br_kind    = mips_pkg::BR_JABS;
				ctrl_o.inst_valid = 1'b1;
			end
			`MIPS_OP_JAL: begin
				ctrl_o.br_kind    = mips_pkg::BR_JABS;
				ctrl_o.alu_op     = mips_pkg::ALU_JAL;
				ctrl_o.we         = 1'b1;
				ctrl_o.waddr      = `MIPS_RADDR_W'(`MIPS_LINK_REG);
				ctrl_o.link       = 1'b1;
				ctrl_o.inst_valid = 1'b1;
			end
			default: ;
		endcase

		if (itype) begin
			ctrl_o.reg1_re    = 1'b1;
			ctrl_o.we         = 1'b1;
			ctrl_o.waddr      = rt;
			ctrl_o.inst_valid = 1'b1;
		end

		// result class follows from the op, any branch kind is jump-branch
		if (ctrl_o.br_kind != mips_pkg::BR_NONE) begin
			ctrl_o.alu_sel = mips_pkg::SEL_JUMP;
		end else begin
			case (ctrl_o.alu_op)
				mips_pkg::ALU_OR, mips_pkg::ALU_AND,
				mips_pkg::ALU_XOR, mips_pkg::ALU_NOR:  ctrl_o.alu_sel = mips_pkg::SEL_LOGIC;
				mips_pkg::ALU_ADDU, mips_pkg::ALU_SUBU,
				mips_pkg::ALU_SLT:                     ctrl_o.alu_sel = mips_pkg::SEL_ARITH;
				mips_pkg::ALU_LW, mips_pkg::ALU_SW:    ctrl_o.alu_sel = mips_pkg::SEL_LOADSTORE;
				default:                               ctrl_o.alu_sel = mips_pkg::SEL_NOP;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`include "mips_params.svh"
`default_nettype none
`timescale 1ns/1ns

module regfile (
	input  wire                           clk_i,
	input  wire                           arst_n_i,
	input  wire mips_pkg::wb_t            wb_i,
	input  wire [`MIPS_RADDR_W-1:0]       raddr1_i,
	input  wire [`MIPS_RADDR_W-1:0]       raddr2_i,
	output logic [`MIPS_XLEN-1:0]         rdata1_o,
	output logic [`MIPS_XLEN-1:0]         rdata2_o
);

	logic [`MIPS_XLEN-1:0] regs_q [`MIPS_NREGS];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_i.en && (wb_i.addr != '0)) begin  // $zero stays zero
			regs_q[wb_i.addr] <= wb_i.data;
		end
	end

	// no write bypass, a same-cycle write shows up next cycle
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

// File: hw/pipe_reg.sv
`default_nettype none
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire           clk_i,
	input  wire           arst_n_i,
	input  wire           in_valid_i,
	output logic          in_ready_o,
	input  wire payload_t in_i,
	output logic          out_valid_o,
	input  wire           out_ready_i,
	output payload_t      out_o
);

	logic     full_q;
	payload_t data_q;
	logic     load;

	assign in_ready_o = ~full_q | out_ready_i;  // slot frees in the same cycle
	assign load       = in_valid_i & in_ready_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q <= 1'b0;
		end else if (load) begin
			full_q <= 1'b1;
		end else if (out_ready_i) begin
			full_q <= 1'b0;  // drained, nothing new
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			data_q <= in_i;
		end
	end

	assign out_valid_o = full_q;
	assign out_o       = data_q;

endmodule

`default_nettype wire

// File: hw/mips_pkg.sv
`include "mips_params.svh"
`default_nettype none

package mips_pkg;

	// operation handed to execute
	typedef enum logic [3:0] {
		ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_ADDU,
		ALU_SUBU, ALU_SLT, ALU_LW, ALU_SW, ALU_JAL
	} alu_op_e;

	// result class
	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_ARITH, SEL_LOADSTORE, SEL_JUMP
	} alu_sel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_JABS, BR_JREG
	} br_kind_e;

	typedef struct packed {
		logic [`MIPS_XLEN-1:0] pc;
		logic [`MIPS_XLEN-1:0] inst;
	} fetch_t;

	typedef struct packed {
		alu_op_e                  alu_op;
		alu_sel_e                 alu_sel;
		br_kind_e                 br_kind;
		logic                     reg1_re;
		logic                     reg2_re;
		logic                     we;
		logic [`MIPS_RADDR_W-1:0] waddr;
		logic [`MIPS_XLEN-1:0]    imm;
		logic                     link;
		logic                     inst_valid;
	} ctrl_t;

	// result of a later stage, is_load only meaningful from execute
	typedef struct packed {
		logic                     we;
		logic [`MIPS_RADDR_W-1:0] waddr;
		logic [`MIPS_XLEN-1:0]    wdata;
		logic                     is_load;
	} fwd_t;

	typedef struct packed {
		logic                     en;
		logic [`MIPS_RADDR_W-1:0] addr;
		logic [`MIPS_XLEN-1:0]    data;
	} wb_t;

	typedef struct packed {
		logic [`MIPS_XLEN-1:0]    pc;
		logic [`MIPS_XLEN-1:0]    inst;
		alu_op_e                  alu_op;
		alu_sel_e                 alu_sel;
		logic [`MIPS_XLEN-1:0]    op1;
		logic [`MIPS_XLEN-1:0]    op2;
		logic [`MIPS_RADDR_W-1:0] waddr;
		logic                     we;
		logic [`MIPS_XLEN-1:0]    link_addr;
		logic                     br_taken;
		logic [`MIPS_XLEN-1:0]    br_target;
		logic                     delay_slot;
		logic                     inst_valid;
	} issue_t;

endpackage

`default_nettype wire

// File: hw/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH
`default_nettype none

// datapath sizes
`define MIPS_XLEN      32
`define MIPS_RADDR_W   5
`define MIPS_NREGS     32
`define MIPS_LINK_REG  31   // jal writes here

// primary opcodes, inst[31:26]
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_J       6'b000010
`define MIPS_OP_JAL     6'b000011
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_SLTI    6'b001010
`define MIPS_OP_ANDI    6'b001100
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_XORI    6'b001110
`define MIPS_OP_LUI     6'b001111
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_SW      6'b101011

// special function codes, inst[5:0]
`define MIPS_FN_JR      6'b001000
`define MIPS_FN_ADDU    6'b100001
`define MIPS_FN_SUBU    6'b100011
`define MIPS_FN_AND     6'b100100
`define MIPS_FN_OR      6'b100101
`define MIPS_FN_XOR     6'b100110
`define MIPS_FN_NOR     6'b100111
`define MIPS_FN_SLT     6'b101010

`default_nettype wire
`endif
